/* tb_vlsu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vlsu;
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    typedef struct {
        vlsu_op_e    op;
        addr_mode_e  mode;
        elem_width_e width;
        word_t       base;
        word_t       stride;
        elem_idx_t   vl;
        logic        vm;
        elem_mask_t  mask;
        vreg_t       wdata;
    } op_entry_t;

    logic        clk;
    logic        reset_n;
    logic        start_i;
    vlsu_op_e    op_i;
    addr_mode_e  addr_mode_i;
    elem_width_e width_i;
    word_t       base_address_i;
    word_t       stride_i;
    elem_idx_t   vl_i;
    logic        vm_i;
    elem_mask_t  mask_i;
    vreg_t       write_data_i;
    word_t       mem_address_o;
    logic        mem_read_enable_o;
    byte_en_t    mem_write_enable_o;
    word_t       mem_write_data_o;
    word_t       mem_read_data;
    logic        hold_o;
    vreg_t       read_data_o;

    op_entry_t   ops_q[$];
    logic [7:0]  ref_mem [256];
    int          seed = 2;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    vlsu_top u_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start_i),
        .op_i               (op_i),
        .addr_mode_i        (addr_mode_i),
        .width_i            (width_i),
        .base_address_i     (base_address_i),
        .stride_i           (stride_i),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .write_data_i       (write_data_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o),
        .mem_read_data_i    (mem_read_data),
        .hold_o             (hold_o),
        .read_data_o        (read_data_o)
    );

    tb_vlsu_mem u_mem (
        .clk            (clk),
        .address_i      (mem_address_o),
        .read_enable_i  (mem_read_enable_o),
        .write_enable_i (mem_write_enable_o),
        .write_data_i   (mem_write_data_o),
        .read_data_o    (mem_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, hold_o never fell", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic add_entry(input vlsu_op_e op, input addr_mode_e mode,
                             input elem_width_e width, input word_t base, input word_t stride,
                             input elem_idx_t vl, input logic vm);
        op_entry_t e;
        e.op     = op;
        e.mode   = mode;
        e.width  = width;
        e.base   = base;
        e.stride = stride;
        e.vl     = vl;
        e.vm     = vm;
        e.mask   = 8'($random(seed));
        e.wdata  = {$random(seed), $random(seed)};
        ops_q.push_back(e);
    endtask

    ////////////////////////////////////////////////////////////////
    // Reference model from the beat rule
    ////////////////////////////////////////////////////////////////

    function automatic int element_address(input op_entry_t e, input int i);
        if (e.mode == UNIT_STRIDED) begin
            return int'(e.base) + i * (1 << e.width);
        end
        return int'(e.base) + i * int'(e.stride);
    endfunction

    // Word address of beat k, counted from zero
    function automatic word_t beat_address(input op_entry_t e, input int k);
        if (e.mode == UNIT_STRIDED) begin
            return e.base + word_t'(4 * k);
        end
        return e.base + word_t'(k) * e.stride;
    endfunction

    function automatic int beat_count(input op_entry_t e);
        int per_beat;
        per_beat = (e.mode == UNIT_STRIDED) ? (4 >> e.width) : 1;
        return (int'(e.vl) + per_beat - 1) / per_beat;
    endfunction

    function automatic logic [63:0] expected_load(input op_entry_t e);
        logic [63:0] v;
        int          ebytes;
        v = '0;
        ebytes = 1 << e.width;
        for (int i = 0; i < e.vl; i++) begin
            for (int b = 0; b < ebytes; b++) begin
                v[8*(i*ebytes + b) +: 8] = ref_mem[(element_address(e, i) + b) & 255];
            end
        end
        return v;
    endfunction

    task automatic apply_store_to_model(input op_entry_t e);
        int ebytes;
        ebytes = 1 << e.width;
        for (int i = 0; i < e.vl; i++) begin
            if (e.vm || e.mask[i]) begin
                for (int b = 0; b < ebytes; b++) begin
                    ref_mem[(element_address(e, i) + b) & 255] = e.wdata[8*(i*ebytes + b) +: 8];
                end
            end
        end
    endtask

    task automatic run_op(input op_entry_t e);
        int n;
        int cycles;
        n = beat_count(e);
        @(posedge clk);
        start_i        <= 1'b1;
        op_i           <= e.op;
        addr_mode_i    <= e.mode;
        width_i        <= e.width;
        base_address_i <= e.base;
        stride_i       <= e.stride;
        vl_i           <= e.vl;
        vm_i           <= e.vm;
        mask_i         <= e.mask;
        write_data_i   <= e.wdata;
        @(posedge clk);
        start_i <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (hold_o) begin
            // Cycle cycles+1 after start
            compare("mem_read_enable_o", (e.op == VLSU_LOAD) && (cycles < n), mem_read_enable_o);
            if (cycles < n) begin
                compare("mem_address_o", beat_address(e, cycles), mem_address_o);
            end
            if (e.op == VLSU_LOAD) begin
                compare("mem_write_enable_o", '0, mem_write_enable_o);
            end
            cycles++;
            @(negedge clk);
        end
        if (cycles != n + 1) begin
            errors++;
            $display("hold_o was high for %0d cycles instead of %0d", cycles, n + 1);
        end
        compare("mem_write_enable_o", '0, mem_write_enable_o);
        if (e.op == VLSU_LOAD) begin
            compare("read_data_o", expected_load(e), read_data_o);
        end else begin
            apply_store_to_model(e);
            for (int a = 0; a < 256; a++) begin
                compare($sformatf("mem[%0d]", a), ref_mem[a], u_mem.mem[a]);
            end
        end
    endtask

    initial begin
        reset_n        = 1'b0;
        start_i        = 1'b0;
        op_i           = VLSU_LOAD;
        addr_mode_i    = UNIT_STRIDED;
        width_i        = EW8;
        base_address_i = '0;
        stride_i       = '0;
        vl_i           = elem_idx_t'(1);
        vm_i           = 1'b1;
        mask_i         = '0;
        write_data_i   = '0;

        // Same random byte in the memory and in its model
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = 8'($random(seed));
            u_mem.mem[a] = ref_mem[a];
        end

        // Full and short unit-strided loads
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW8,  32'h10, 32'd0,  4'd8, 1'b1);
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW16, 32'h24, 32'd0,  4'd4, 1'b1);
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW32, 32'h30, 32'd0,  4'd2, 1'b1);
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW8,  32'h40, 32'd0,  4'd5, 1'b1);
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW16, 32'h48, 32'd0,  4'd3, 1'b1);
        // Strided loads, one with a negative stride
        add_entry(VLSU_LOAD,  STRIDED,      EW8,  32'h50, 32'd3,  4'd8, 1'b1);
        add_entry(VLSU_LOAD,  STRIDED,      EW16, 32'h80, -32'sd6, 4'd4, 1'b1);
        add_entry(VLSU_LOAD,  STRIDED,      EW32, 32'h90, 32'd12, 4'd2, 1'b1);
        // Unmasked stores
        add_entry(VLSU_STORE, UNIT_STRIDED, EW8,  32'hA0, 32'd0,  4'd8, 1'b1);
        add_entry(VLSU_STORE, UNIT_STRIDED, EW16, 32'hA8, 32'd0,  4'd3, 1'b1);
        add_entry(VLSU_STORE, UNIT_STRIDED, EW32, 32'hB0, 32'd0,  4'd2, 1'b1);
        add_entry(VLSU_STORE, STRIDED,      EW8,  32'hC0, 32'd5,  4'd6, 1'b1);
        add_entry(VLSU_STORE, STRIDED,      EW16, 32'hD0, -32'sd4, 4'd4, 1'b1);
        add_entry(VLSU_STORE, STRIDED,      EW32, 32'hE0, 32'd8,  4'd2, 1'b1);
        // Masked stores
        add_entry(VLSU_STORE, UNIT_STRIDED, EW8,  32'h60, 32'd0,  4'd8, 1'b0);
        add_entry(VLSU_STORE, STRIDED,      EW16, 32'hF0, -32'sd2, 4'd4, 1'b0);
        // Read back a stored region
        add_entry(VLSU_LOAD,  UNIT_STRIDED, EW8,  32'hA0, 32'd0,  4'd8, 1'b1);
        cycle_limit = ops_q.size() * 16 + 100;

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        compare("hold_o", '0, hold_o);
        compare("mem_read_enable_o", '0, mem_read_enable_o);
        compare("mem_write_enable_o", '0, mem_write_enable_o);
        compare("read_data_o", '0, read_data_o);

        foreach (ops_q[i]) begin
            run_op(ops_q[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_vlsu_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vlsu_mem (
    input  logic        clk,
    input  logic [31:0] address_i,
    input  logic        read_enable_i,
    input  logic [3:0]  write_enable_i,
    input  logic [31:0] write_data_i,
    output logic [31:0] read_data_o
);
    localparam int DEPTH = 256;

    // Byte array, filled by the testbench before reset is released
    logic [7:0] mem [DEPTH];
    logic [7:0] word_base;

    // Word containing the addressed byte
    assign word_base = {address_i[7:2], 2'b00};

    ////////////////////////////////////////////////////////////
    // Synchronous read, one cycle of latency
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (read_enable_i) begin
            for (int b = 0; b < 4; b++) begin
                read_data_o[8*b +: 8] <= mem[word_base + b];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte writes
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (write_enable_i[b]) begin
                mem[word_base + b] <= write_data_i[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* vlsu_address_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module vlsu_address_gen (
    input  logic                        clk,
    input  logic                        reset_n,
    input  vlsu_ctrl_pkg::lsu_state_e   state_i,
    input  logic                        beat_fire_i,
    input  vlsu_ctrl_pkg::addr_mode_e   addr_mode_i,
    input  vlsu_ctrl_pkg::elem_width_e  width_i,
    input  vlsu_cfg_pkg::word_t         base_address_i,
    input  vlsu_cfg_pkg::word_t         stride_i,
    output vlsu_cfg_pkg::word_t         mem_address_o
);
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    word_t      offset;
    logic [1:0] align_mask;

    // Offset is zero during the first beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset <= '0;
        end else if (state_i == LSU_IDLE) begin
            offset <= '0;
        end else if (beat_fire_i) begin
            if (addr_mode_i == UNIT_STRIDED) begin
                offset <= offset + word_t'(WORD_BYTES);
            end else begin
                offset <= offset + stride_i;
            end
        end
    end

    assign mem_address_o = base_address_i + offset;

    // Low address bits that must be zero for the element width
    assign align_mask = 2'((1 << width_i) - 1);

    unit_base_aligned_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (beat_fire_i && addr_mode_i == UNIT_STRIDED) |-> (base_address_i[1:0] == 2'b00)
    );

    strided_addr_aligned_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (beat_fire_i && addr_mode_i == STRIDED) |-> ((mem_address_o[1:0] & align_mask) == 2'b00)
    );

endmodule

`default_nettype wire

/* vlsu_cfg_pkg.sv */
`default_nettype none

package vlsu_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath geometry
    ////////////////////////////////////////////////////////////

    // One vector register
    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    // Memory port
    localparam int WORD_BYTES = 4;

    ////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////

    typedef logic [VLEN-1:0]       vreg_t;
    typedef logic [31:0]           word_t;
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    // Needs to hold VLENB itself as a count
    typedef logic [3:0]            elem_idx_t;

    typedef logic [VLENB-1:0]      elem_mask_t;

endpackage

`default_nettype wire

/* vlsu_ctrl_pkg.sv */
`default_nettype none

package vlsu_ctrl_pkg;

    typedef enum logic {
        VLSU_LOAD  = 1'b0,
        VLSU_STORE = 1'b1
    } vlsu_op_e;

    typedef enum logic {
        UNIT_STRIDED = 1'b0,
        STRIDED      = 1'b1
    } addr_mode_e;

    // Value is log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        LSU_IDLE   = 2'd0,
        LSU_ACCESS = 2'd1,
        LSU_DRAIN  = 2'd2
    } lsu_state_e;

endpackage

`default_nettype wire

/* vlsu_load_align.sv */
`timescale 1ns/1ns
`default_nettype none

module vlsu_load_align (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start_i,
    input  vlsu_ctrl_pkg::vlsu_op_e     op_i,
    input  vlsu_ctrl_pkg::addr_mode_e   addr_mode_i,
    input  vlsu_ctrl_pkg::elem_width_e  width_i,
    input  logic                        beat_fire_i,
    input  vlsu_cfg_pkg::elem_idx_t     elem_index_i,
    input  vlsu_cfg_pkg::elem_idx_t     beat_elems_i,
    input  vlsu_cfg_pkg::word_t         address_i,
    input  vlsu_cfg_pkg::word_t         mem_read_data_i,
    output vlsu_cfg_pkg::vreg_t         read_data_o
);
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    logic                       load_beat_r;
    elem_idx_t                  elem_index_r;
    elem_idx_t                  beat_elems_r;
    logic [1:0]                 addr_lo_r;

    logic [WORD_BYTES-1:0]      byte_valid;
    logic [WORD_BYTES-1:0][2:0] dst_byte;
    logic [WORD_BYTES-1:0][7:0] src_byte;
    logic [1:0]                 src_lane [WORD_BYTES];

    ////////////////////////////////////////////////////////////
    // Stage 1 to stage 2 barrier
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            load_beat_r <= 1'b0;
        end else begin
            load_beat_r <= beat_fire_i && (op_i == VLSU_LOAD);
        end
    end

    // Beat description travels alongside the memory access
    always_ff @(posedge clk) begin
        elem_index_r <= elem_index_i;
        beat_elems_r <= beat_elems_i;
        addr_lo_r    <= address_i[1:0];
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 placement
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < WORD_BYTES; p++) begin
            // Byte p of the beat belongs to element p >> width
            byte_valid[p] = ((p >> width_i) < int'(beat_elems_r));
            dst_byte[p]   = 3'((int'(elem_index_r) << width_i) + p);
            if (addr_mode_i == UNIT_STRIDED) begin
                src_lane[p] = 2'(p);
            end else begin
                src_lane[p] = 2'(int'(addr_lo_r) + p);
            end
            src_byte[p] = mem_read_data_i[8*src_lane[p] +: 8];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= '0;
        end else if (start_i) begin
            read_data_o <= '0;
        end else if (load_beat_r) begin
            for (int p = 0; p < WORD_BYTES; p++) begin
                if (byte_valid[p]) begin
                    read_data_o[8*dst_byte[p] +: 8] <= src_byte[p];
                end
            end
        end
    end

    // A load beat always puts at least one element in place
    load_beat_nonempty_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        load_beat_r |-> (beat_elems_r != '0)
    );

endmodule

`default_nettype wire

/* vlsu_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module vlsu_sequencer (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start_i,
    input  vlsu_ctrl_pkg::vlsu_op_e     op_i,
    input  vlsu_ctrl_pkg::addr_mode_e   addr_mode_i,
    input  vlsu_ctrl_pkg::elem_width_e  width_i,
    input  vlsu_cfg_pkg::elem_idx_t     vl_i,
    output vlsu_ctrl_pkg::lsu_state_e   state_o,
    output logic                        beat_fire_o,
    output vlsu_cfg_pkg::elem_idx_t     elem_index_o,
    output vlsu_cfg_pkg::elem_idx_t     beat_elems_o,
    output logic                        hold_o,
    output logic                        mem_read_enable_o
);
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    lsu_state_e state;
    lsu_state_e next_state;
    elem_idx_t  elem_index;
    elem_idx_t  beat_size;
    elem_idx_t  next_index;
    elem_idx_t  remaining;
    elem_idx_t  elems_per_reg;

    assign elems_per_reg = elem_idx_t'(VLENB >> width_i);

    // Unit-strided beats fill a whole word, strided beats carry one element
    always_comb begin
        if (addr_mode_i == UNIT_STRIDED) begin
            beat_size = elem_idx_t'(WORD_BYTES >> width_i);
        end else begin
            beat_size = elem_idx_t'(1);
        end
    end

    assign next_index = elem_index + beat_size;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= LSU_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        unique case (state)
            LSU_IDLE:   next_state = start_i ? LSU_ACCESS : LSU_IDLE;
            LSU_ACCESS: next_state = (next_index >= vl_i) ? LSU_DRAIN : LSU_ACCESS;
            default:    next_state = LSU_IDLE;
        endcase
    end

    // First element of the current beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            elem_index <= '0;
        end else if (state == LSU_IDLE) begin
            elem_index <= '0;
        end else if (state == LSU_ACCESS) begin
            elem_index <= next_index;
        end
    end

    // Elements of this beat that lie below vl
    assign remaining = (vl_i > elem_index) ? (vl_i - elem_index) : '0;
    assign beat_elems_o = (remaining < beat_size) ? remaining : beat_size;

    assign state_o           = state;
    assign elem_index_o      = elem_index;
    assign beat_fire_o       = (state == LSU_ACCESS);
    assign hold_o            = (state != LSU_IDLE);
    assign mem_read_enable_o = (state == LSU_ACCESS) && (op_i == VLSU_LOAD);

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    vl_in_range_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (start_i && state == LSU_IDLE) |-> (vl_i != '0 && vl_i <= elems_per_reg)
    );

    // Environment must wait for the drain to finish
    no_start_while_busy_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        hold_o |-> !start_i
    );

endmodule

`default_nettype wire

/* vlsu_store_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module vlsu_store_lane (
    input  logic                        clk,
    input  vlsu_ctrl_pkg::vlsu_op_e     op_i,
    input  vlsu_ctrl_pkg::addr_mode_e   addr_mode_i,
    input  vlsu_ctrl_pkg::elem_width_e  width_i,
    input  logic                        beat_fire_i,
    input  vlsu_cfg_pkg::elem_idx_t     elem_index_i,
    input  vlsu_cfg_pkg::elem_idx_t     vl_i,
    input  logic                        vm_i,
    input  vlsu_cfg_pkg::elem_mask_t    mask_i,
    input  vlsu_cfg_pkg::vreg_t         write_data_i,
    input  vlsu_cfg_pkg::word_t         address_i,
    output vlsu_cfg_pkg::byte_en_t      mem_write_enable_o,
    output vlsu_cfg_pkg::word_t         mem_write_data_o
);
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    logic                           store_beat;
    logic [1:0]                     part_mask;
    elem_idx_t                      lane_elem [WORD_BYTES];
    logic [WORD_BYTES-1:0][2:0]     lane_byte;
    logic [WORD_BYTES-1:0]          lane_sel;
    logic [WORD_BYTES-1:0]          lane_active;

    assign store_beat = beat_fire_i && (op_i == VLSU_STORE);

    // Byte position inside one element
    assign part_mask = 2'((1 << width_i) - 1);

    ////////////////////////////////////////////////////////////
    // Lane steering
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < WORD_BYTES; l++) begin
            if (addr_mode_i == UNIT_STRIDED) begin
                // Consecutive elements packed from lane 0 upward
                lane_elem[l] = elem_index_i + elem_idx_t'(l >> width_i);
                lane_byte[l] = 3'((int'(elem_index_i) << width_i) + l);
                lane_sel[l]  = 1'b1;
            end else begin
                // One element repeated, enabled where the address points
                lane_elem[l] = elem_index_i;
                lane_byte[l] = 3'((int'(elem_index_i) << width_i) + (l & int'(part_mask)));
                lane_sel[l]  = ((l >> width_i) == (int'(address_i[1:0]) >> width_i));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Enables and data
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < WORD_BYTES; l++) begin
            lane_active[l] = (lane_elem[l] < vl_i)
                          && (vm_i || mask_i[lane_elem[l][2:0]]);
            mem_write_enable_o[l] = store_beat && lane_sel[l] && lane_active[l];
            mem_write_data_o[8*l +: 8] = write_data_i[8*lane_byte[l] +: 8];
        end
    end

    // Enabled store bytes carry known data
    store_data_known_a: assert property (
        @(posedge clk)
        (mem_write_enable_o != '0) |-> !$isunknown(mem_write_data_o)
    );

endmodule

`default_nettype wire

/* vlsu_top.f */
vlsu_cfg_pkg.sv
vlsu_ctrl_pkg.sv
vlsu_sequencer.sv
vlsu_address_gen.sv
vlsu_store_lane.sv
vlsu_load_align.sv
vlsu_top.sv
tb_vlsu_mem.sv
tb_vlsu.sv

/* vlsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module vlsu_top (
    input  logic                        clk,
    input  logic                        reset_n,

    // Operation
    input  logic                        start_i,
    input  vlsu_ctrl_pkg::vlsu_op_e     op_i,
    input  vlsu_ctrl_pkg::addr_mode_e   addr_mode_i,
    input  vlsu_ctrl_pkg::elem_width_e  width_i,
    input  vlsu_cfg_pkg::word_t         base_address_i,
    input  vlsu_cfg_pkg::word_t         stride_i,
    input  vlsu_cfg_pkg::elem_idx_t     vl_i,
    input  logic                        vm_i,
    input  vlsu_cfg_pkg::elem_mask_t    mask_i,
    input  vlsu_cfg_pkg::vreg_t         write_data_i,

    // Memory port
    output vlsu_cfg_pkg::word_t         mem_address_o,
    output logic                        mem_read_enable_o,
    output vlsu_cfg_pkg::byte_en_t      mem_write_enable_o,
    output vlsu_cfg_pkg::word_t         mem_write_data_o,
    input  vlsu_cfg_pkg::word_t         mem_read_data_i,

    // Status and result
    output logic                        hold_o,
    output vlsu_cfg_pkg::vreg_t         read_data_o
);
    import vlsu_cfg_pkg::*;
    import vlsu_ctrl_pkg::*;

    lsu_state_e state;
    logic       beat_fire;
    elem_idx_t  elem_index;
    elem_idx_t  beat_elems;

    vlsu_sequencer u_sequencer (
        .clk               (clk),
        .reset_n           (reset_n),
        .start_i           (start_i),
        .op_i              (op_i),
        .addr_mode_i       (addr_mode_i),
        .width_i           (width_i),
        .vl_i              (vl_i),
        .state_o           (state),
        .beat_fire_o       (beat_fire),
        .elem_index_o      (elem_index),
        .beat_elems_o      (beat_elems),
        .hold_o            (hold_o),
        .mem_read_enable_o (mem_read_enable_o)
    );

    vlsu_address_gen u_address_gen (
        .clk            (clk),
        .reset_n        (reset_n),
        .state_i        (state),
        .beat_fire_i    (beat_fire),
        .addr_mode_i    (addr_mode_i),
        .width_i        (width_i),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .mem_address_o  (mem_address_o)
    );

    vlsu_store_lane u_store_lane (
        .clk                (clk),
        .op_i               (op_i),
        .addr_mode_i        (addr_mode_i),
        .width_i            (width_i),
        .beat_fire_i        (beat_fire),
        .elem_index_i       (elem_index),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .write_data_i       (write_data_i),
        .address_i          (mem_address_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    vlsu_load_align u_load_align (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .op_i            (op_i),
        .addr_mode_i     (addr_mode_i),
        .width_i         (width_i),
        .beat_fire_i     (beat_fire),
        .elem_index_i    (elem_index),
        .beat_elems_i    (beat_elems),
        .address_i       (mem_address_o),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

endmodule

`default_nettype wire
